//--- rtl/dl_pkg.sv
package dl_pkg;

	typedef logic [15:0] frame_idx_t;
	typedef logic [7:0] slot_idx_t;
	typedef logic [7:0] symbol_idx_t;

	localparam logic [15:0] IQ_ETHERTYPE = 16'hAEFE;
	localparam logic [7:0] IQ_SECTION_TYPE = 8'h00;

	// beat index within a frame, sop beat is 0
	localparam int ETH_TYPE_BEAT = 2;
	localparam int SECTION_BEAT = 4;

	typedef struct packed {
		logic [15:0] ethertype;
		logic [6:0] pad_hi;
		logic iq_flag;
		logic [23:0] pad_lo;
		logic [15:0] pc_id;
	} eth_view_t;

	typedef struct packed {
		logic [15:0] pad;
		frame_idx_t frame;
		slot_idx_t slot;
		symbol_idx_t symbol;
		logic [6:0] reserved;
		logic more;
		logic [7:0] sec_type;
	} section_view_t;

	typedef struct packed {
		logic [23:0] pad_hi;
		logic [7:0] ante_idx;
		logic [31:0] pad_lo;
	} ante_view_t;

	// one 64-bit beat, read as whichever header word it is
	typedef union packed {
		eth_view_t eth;
		section_view_t sec;
		ante_view_t ante;
	} dl_beat_u;

	// bits needed to hold 0 .. max_value
	function automatic int cnt_width(input int max_value);
		return (max_value < 1) ? 1 : $clog2(max_value + 1);
	endfunction

endpackage

//--- rtl/arm_bypass.sv
`timescale 1ns/1ps

module arm_bypass
	import dl_pkg::*;
(
	input logic clk_in,
	input logic rst_n,
	input logic [63:0] st_data,
	input logic st_valid,
	input logic st_sop,
	input logic st_eop,
	input logic [2:0] st_empty,
	output logic arm_restart,
	output logic arm_valid,
	output logic arm_sop,
	output logic arm_eop,
	output logic [2:0] arm_empty,
	output logic [63:0] arm_data
);

	localparam int HDR_W = cnt_width(ETH_TYPE_BEAT + 1);

	typedef enum logic {
		RST_IDLE,
		RST_LATCH
	} restart_state_e;

	restart_state_e rst_state;
	logic [HDR_W-1:0] hdr_cnt;
	logic pkt_start;
	logic iq_seen;
	dl_beat_u held_beat;

	assign pkt_start = st_valid && st_sop;
	assign held_beat = arm_data;

	// ethertype is checked on the registered copy
	assign iq_seen = arm_valid && (hdr_cnt == HDR_W'(ETH_TYPE_BEAT)) &&
		(held_beat.eth.ethertype == IQ_ETHERTYPE);

	always_ff @(posedge clk_in or negedge rst_n)
	begin
		if (!rst_n)
		begin
			arm_valid <= 1'b0;
			arm_sop <= 1'b0;
			arm_eop <= 1'b0;
			arm_empty <= '0;
			arm_data <= '0;
		end
		else
		begin
			arm_valid <= st_valid;
			arm_sop <= st_sop;
			arm_eop <= st_eop;
			arm_empty <= st_empty;
			arm_data <= st_data;
		end
	end

	// saturates one past the ethertype beat
	always_ff @(posedge clk_in or negedge rst_n)
	begin
		if (!rst_n)
			hdr_cnt <= '0;
		else if (pkt_start)
			hdr_cnt <= '0;
		else if (st_valid && (hdr_cnt != HDR_W'(ETH_TYPE_BEAT + 1)))
			hdr_cnt <= hdr_cnt + 1'b1;
	end

	always_ff @(posedge clk_in or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rst_state <= RST_IDLE;
			arm_restart <= 1'b0;
		end
		else
		begin
			case (rst_state)
				RST_IDLE:
				begin
					arm_restart <= 1'b0;
					if (iq_seen)
						rst_state <= RST_LATCH;
				end
				RST_LATCH:
				begin
					arm_restart <= 1'b1;
					if (pkt_start)
						rst_state <= RST_IDLE;
				end
				default:
				begin
					rst_state <= RST_IDLE;
					arm_restart <= 1'b0;
				end
			endcase
		end
	end

endmodule

//--- rtl/iq_section_parser.sv
`timescale 1ns/1ps

module iq_section_parser
	import dl_pkg::*;
#(
	parameter int ANTE_NUM = 8,
	parameter int SCS_NUM = 3276,
	localparam int ANTE_W = cnt_width(ANTE_NUM - 1)
)
(
	input logic clk_in,
	input logic rst_n,
	input dl_beat_u st_data,
	input logic st_valid,
	input logic st_sop,
	input logic st_eop,
	output logic beat_we,
	output logic beat_first,
	output logic beat_last,
	output logic [ANTE_W-1:0] beat_ante,
	output logic [63:0] beat_data,
	output frame_idx_t sec_frame,
	output slot_idx_t sec_slot,
	output symbol_idx_t sec_symbol
);

	localparam int BLK_BEATS = SCS_NUM / 4;
	localparam int BLK_W = cnt_width(BLK_BEATS - 1);
	localparam int IDX_W = cnt_width(SECTION_BEAT + 1);

	typedef enum logic [2:0] {
		S_IDLE,
		S_CHECK_ETH,
		S_CHECK_SEC,
		S_GET_LST_INDEX,
		S_GET_INDEX,
		S_LST_BLOCK_OUT,
		S_BLOCK_OUT,
		S_REPEAT
	} parse_state_e;

	parse_state_e state;
	parse_state_e state_nxt;
	logic [IDX_W-1:0] beat_cnt;
	logic [IDX_W-1:0] beat_idx;
	logic [BLK_W-1:0] blk_cnt;
	logic [ANTE_W-1:0] ante_q;
	logic pkt_start;
	logic eth_ok;
	logic sec_ok;
	logic in_block;
	logic get_index;
	logic blk_end;

	assign pkt_start = st_valid && st_sop;
	assign beat_idx = st_sop ? '0 : beat_cnt;

	assign eth_ok = (st_data.eth.ethertype == IQ_ETHERTYPE) && st_data.eth.iq_flag &&
		(st_data.eth.pc_id == '0);
	assign sec_ok = (st_data.sec.sec_type == IQ_SECTION_TYPE);

	assign in_block = (state == S_LST_BLOCK_OUT) || (state == S_BLOCK_OUT);
	assign get_index = (state == S_GET_LST_INDEX) || (state == S_GET_INDEX);
	assign blk_end = (blk_cnt == BLK_W'(BLK_BEATS - 1));

	// index of the next beat, held once past the section header
	always_ff @(posedge clk_in or negedge rst_n)
	begin
		if (!rst_n)
			beat_cnt <= '0;
		else if (st_valid)
		begin
			if (st_sop)
				beat_cnt <= IDX_W'(1);
			else if (beat_cnt != IDX_W'(SECTION_BEAT + 1))
				beat_cnt <= beat_cnt + 1'b1;
		end
	end

	always_comb
	begin
		state_nxt = state;
		case (state)
			S_IDLE:
				state_nxt = S_IDLE;
			S_CHECK_ETH:
				if (st_valid && (beat_idx == IDX_W'(ETH_TYPE_BEAT)))
					state_nxt = eth_ok ? S_CHECK_SEC : S_IDLE;
			S_CHECK_SEC:
				if (st_valid && (beat_idx == IDX_W'(SECTION_BEAT)))
				begin
					if (!sec_ok)
						state_nxt = S_IDLE;
					else if (st_data.sec.more)
						state_nxt = S_GET_INDEX;
					else
						state_nxt = S_GET_LST_INDEX;
				end
			S_GET_LST_INDEX:
				if (st_valid)
					state_nxt = S_LST_BLOCK_OUT;
			S_GET_INDEX:
				if (st_valid)
					state_nxt = S_BLOCK_OUT;
			S_LST_BLOCK_OUT:
				if (st_valid && blk_end)
					state_nxt = S_IDLE;
			S_BLOCK_OUT:
				if (st_valid && blk_end)
					state_nxt = S_REPEAT;
			S_REPEAT:
				// repeat beat carries the next more flag
				if (st_valid)
					state_nxt = st_data.sec.more ? S_GET_INDEX : S_GET_LST_INDEX;
			default:
				state_nxt = S_IDLE;
		endcase
		// any new frame restarts the parse
		if (pkt_start)
			state_nxt = S_CHECK_ETH;
	end

	always_ff @(posedge clk_in or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= S_IDLE;
			blk_cnt <= '0;
			ante_q <= '0;
		end
		else
		begin
			state <= state_nxt;
			if (get_index && st_valid)
			begin
				blk_cnt <= '0;
				ante_q <= st_data.ante.ante_idx[ANTE_W-1:0];
			end
			else if (beat_we)
				blk_cnt <= blk_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk_in)
	begin
		if ((state == S_CHECK_SEC) && st_valid && (beat_idx == IDX_W'(SECTION_BEAT)) && sec_ok)
		begin
			sec_frame <= st_data.sec.frame;
			sec_slot <= st_data.sec.slot;
			sec_symbol <= st_data.sec.symbol;
		end
	end

	// an eop inside a block ends nothing here, the beat count does
	assign beat_we = in_block && st_valid && !st_sop;
	assign beat_first = (blk_cnt == '0);
	assign beat_last = blk_end || st_eop;
	assign beat_ante = ante_q;
	assign beat_data = st_data;

endmodule

//--- rtl/ante_fanout.sv
`timescale 1ns/1ps

module ante_fanout
	import dl_pkg::*;
#(
	parameter int ANTE_NUM = 8,
	localparam int ANTE_W = cnt_width(ANTE_NUM - 1)
)
(
	input logic clk_in,
	input logic rst_n,
	input logic beat_we,
	input logic beat_first,
	input logic beat_last,
	input logic [ANTE_W-1:0] beat_ante,
	input logic [63:0] beat_data,
	input frame_idx_t sec_frame,
	input slot_idx_t sec_slot,
	input symbol_idx_t sec_symbol,
	output logic [ANTE_NUM-1:0] ante_valid,
	output logic [ANTE_NUM-1:0] ante_sop,
	output logic [ANTE_NUM-1:0] ante_eop,
	output logic [ANTE_NUM-1:0][63:0] ante_data,
	output frame_idx_t [ANTE_NUM-1:0] ante_frame,
	output slot_idx_t [ANTE_NUM-1:0] ante_slot,
	output symbol_idx_t [ANTE_NUM-1:0] ante_symbol
);

	logic [ANTE_NUM-1:0] hit;

	// one-hot antenna select for the current beat
	always_comb
	begin
		for (int i = 0; i < ANTE_NUM; i++)
			hit[i] = beat_we && (beat_ante == ANTE_W'(i));
	end

	always_ff @(posedge clk_in or negedge rst_n)
	begin
		if (!rst_n)
		begin
			ante_valid <= '0;
			ante_sop <= '0;
			ante_eop <= '0;
		end
		else
		begin
			ante_valid <= hit;
			ante_sop <= hit & {ANTE_NUM{beat_first}};
			ante_eop <= hit & {ANTE_NUM{beat_last}};
		end
	end

	// unselected antennas hold their last beat and indices
	always_ff @(posedge clk_in)
	begin
		for (int i = 0; i < ANTE_NUM; i++)
		begin
			if (hit[i])
			begin
				ante_data[i] <= beat_data;
				ante_frame[i] <= sec_frame;
				ante_slot[i] <= sec_slot;
				ante_symbol[i] <= sec_symbol;
			end
		end
	end

endmodule

//--- rtl/dl_distribt.sv
`timescale 1ns/1ps

module dl_distribt
	import dl_pkg::*;
#(
	parameter int ANTE_NUM = 8,
	parameter int SCS_NUM = 3276
)
(
	input logic clk_in,
	input logic rst_n,
	input logic [63:0] st_data,
	input logic st_valid,
	input logic st_sop,
	input logic st_eop,
	input logic [2:0] st_empty,
	input logic st_error,
	output logic st_ready,
	output logic arm_restart,
	output logic arm_valid,
	output logic arm_sop,
	output logic arm_eop,
	output logic [2:0] arm_empty,
	output logic [63:0] arm_data,
	output logic [ANTE_NUM-1:0] ante_valid,
	output logic [ANTE_NUM-1:0] ante_sop,
	output logic [ANTE_NUM-1:0] ante_eop,
	output logic [ANTE_NUM-1:0][63:0] ante_data,
	output frame_idx_t [ANTE_NUM-1:0] ante_frame,
	output slot_idx_t [ANTE_NUM-1:0] ante_slot,
	output symbol_idx_t [ANTE_NUM-1:0] ante_symbol
);

	localparam int ANTE_W = cnt_width(ANTE_NUM - 1);

	logic beat_we;
	logic beat_first;
	logic beat_last;
	logic [ANTE_W-1:0] beat_ante;
	logic [63:0] beat_data;
	frame_idx_t sec_frame;
	slot_idx_t sec_slot;
	symbol_idx_t sec_symbol;

	// no back-pressure, ready once out of reset
	// st_error is taken with the beat and has no effect
	assign st_ready = rst_n;

	arm_bypass u_arm_bypass (
		.clk_in (clk_in),
		.rst_n (rst_n),
		.st_data (st_data),
		.st_valid (st_valid),
		.st_sop (st_sop),
		.st_eop (st_eop),
		.st_empty (st_empty),
		.arm_restart (arm_restart),
		.arm_valid (arm_valid),
		.arm_sop (arm_sop),
		.arm_eop (arm_eop),
		.arm_empty (arm_empty),
		.arm_data (arm_data)
	);

	iq_section_parser #(
		.ANTE_NUM (ANTE_NUM),
		.SCS_NUM (SCS_NUM)
	) u_iq_section_parser (
		.clk_in (clk_in),
		.rst_n (rst_n),
		.st_data (st_data),
		.st_valid (st_valid),
		.st_sop (st_sop),
		.st_eop (st_eop),
		.beat_we (beat_we),
		.beat_first (beat_first),
		.beat_last (beat_last),
		.beat_ante (beat_ante),
		.beat_data (beat_data),
		.sec_frame (sec_frame),
		.sec_slot (sec_slot),
		.sec_symbol (sec_symbol)
	);

	ante_fanout #(
		.ANTE_NUM (ANTE_NUM)
	) u_ante_fanout (
		.clk_in (clk_in),
		.rst_n (rst_n),
		.beat_we (beat_we),
		.beat_first (beat_first),
		.beat_last (beat_last),
		.beat_ante (beat_ante),
		.beat_data (beat_data),
		.sec_frame (sec_frame),
		.sec_slot (sec_slot),
		.sec_symbol (sec_symbol),
		.ante_valid (ante_valid),
		.ante_sop (ante_sop),
		.ante_eop (ante_eop),
		.ante_data (ante_data),
		.ante_frame (ante_frame),
		.ante_slot (ante_slot),
		.ante_symbol (ante_symbol)
	);

endmodule

//--- include/dl_tb_frames.svh
`ifndef DL_TB_FRAMES_SVH
`define DL_TB_FRAMES_SVH

// filler for header pads and payload
function automatic logic [63:0] rand_word();
	return {$random(seed), $random(seed)};
endfunction

// ethertype 63:48, iq flag 40, pc id 15:0
function automatic logic [63:0] eth_word(input logic [63:0] fill, input logic [15:0] etype,
	input logic iq_flag, input logic [15:0] pc_id);
	logic [63:0] w;
	w = fill;
	w[63:48] = etype;
	w[40] = iq_flag;
	w[15:0] = pc_id;
	return w;
endfunction

// frame 47:32, slot 31:24, symbol 23:16, more 8, section type 7:0
function automatic logic [63:0] sec_word(input logic [63:0] fill, input logic [15:0] frame,
	input logic [7:0] slot, input logic [7:0] symbol, input logic more, input logic [7:0] stype);
	logic [63:0] w;
	w = fill;
	w[47:32] = frame;
	w[31:24] = slot;
	w[23:16] = symbol;
	w[8] = more;
	w[7:0] = stype;
	return w;
endfunction

// repeat beat only carries a new more flag
function automatic logic [63:0] repeat_word(input logic [63:0] fill, input logic more);
	logic [63:0] w;
	w = fill;
	w[8] = more;
	return w;
endfunction

// antenna index in 39:32
function automatic logic [63:0] index_word(input logic [63:0] fill, input logic [7:0] idx);
	logic [63:0] w;
	w = fill;
	w[39:32] = idx;
	return w;
endfunction

// low index bits pick the antenna
function automatic int ante_of(input logic [7:0] idx);
	return idx % ANTE_N;
endfunction

function automatic logic [ANTE_N-1:0] ante_mask(input int ante);
	return ANTE_N'(1) << ante;
endfunction

`endif

//--- dv/dl_distribt_tb.sv
`timescale 1ns/1ps

module dl_distribt_tb
	import dl_pkg::*;
();

	localparam int ANTE_N = 8;
	localparam int SCS_N = 32;
	localparam int BLK_LEN = SCS_N / 4;
	localparam int TAIL_LEN = 4;
	localparam int MAX_BEATS = 64;
	// the tests take about 150 cycles
	localparam int MAX_CYCLES = 2000;

	logic clk_in;
	logic rst_n;
	logic [63:0] st_data;
	logic st_valid;
	logic st_sop;
	logic st_eop;
	logic [2:0] st_empty;
	logic st_error;
	logic st_ready;
	logic arm_restart;
	logic arm_valid;
	logic arm_sop;
	logic arm_eop;
	logic [2:0] arm_empty;
	logic [63:0] arm_data;
	logic [ANTE_N-1:0] ante_valid;
	logic [ANTE_N-1:0] ante_sop;
	logic [ANTE_N-1:0] ante_eop;
	logic [ANTE_N-1:0][63:0] ante_data;
	frame_idx_t [ANTE_N-1:0] ante_frame;
	slot_idx_t [ANTE_N-1:0] ante_slot;
	symbol_idx_t [ANTE_N-1:0] ante_symbol;

	// driven beats and the routing each one should get
	logic s_valid [MAX_BEATS];
	logic s_sop [MAX_BEATS];
	logic s_eop [MAX_BEATS];
	logic [2:0] s_empty [MAX_BEATS];
	logic [63:0] s_data [MAX_BEATS];
	logic s_we [MAX_BEATS];
	int s_ante [MAX_BEATS];
	logic s_first [MAX_BEATS];
	logic s_last [MAX_BEATS];

	// outputs seen at the falling edge after each driven beat
	logic c_restart [MAX_BEATS];
	logic [5:0] c_arm [MAX_BEATS];
	logic [63:0] c_arm_data [MAX_BEATS];
	logic [ANTE_N-1:0] c_valid [MAX_BEATS];
	logic [ANTE_N-1:0] c_sop [MAX_BEATS];
	logic [ANTE_N-1:0] c_eop [MAX_BEATS];
	logic [ANTE_N-1:0][63:0] c_data [MAX_BEATS];
	frame_idx_t [ANTE_N-1:0] c_frame [MAX_BEATS];
	slot_idx_t [ANTE_N-1:0] c_slot [MAX_BEATS];
	symbol_idx_t [ANTE_N-1:0] c_symbol [MAX_BEATS];

	integer seed;
	int n_beats;
	int err_cnt = 0;
	int err_start;
	int test_cnt = 0;
	int cycle_cnt = 0;
	string test_name;
	frame_idx_t hdr_frame;
	slot_idx_t hdr_slot;
	symbol_idx_t hdr_symbol;

	`include "dl_tb_frames.svh"

	dl_distribt #(
		.ANTE_NUM (ANTE_N),
		.SCS_NUM (SCS_N)
	) u_dl_distribt (.*);

	initial
	begin
		clk_in = 1'b0;
		forever
			#10 clk_in = ~clk_in;
	end

	always @(posedge clk_in)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES)
		begin
			$display("timeout: run still going after %0d cycles", MAX_CYCLES);
			$display("TEST FAILED");
			$finish;
		end
	end

	task automatic mismatch(input string what, input int j, input logic [63:0] exp,
		input logic [63:0] act);
		err_cnt++;
		$display("CHECK FAILED %s: %s at beat %0d expected %h actual %h",
			test_name, what, j, exp, act);
	endtask

	task automatic start_test(input string name);
		test_name = name;
		err_start = err_cnt;
		n_beats = 0;
		hdr_frame = 16'($random(seed));
		hdr_slot = 8'($random(seed));
		hdr_symbol = 8'($random(seed));
	endtask

	task automatic end_test();
		test_cnt++;
		if (err_cnt == err_start)
			$display("test %s: ok", test_name);
		else
			$display("test %s: %0d errors", test_name, err_cnt - err_start);
	endtask

	task automatic add_beat(input logic v, input logic s, input logic e, input logic [63:0] d);
		s_valid[n_beats] = v;
		s_sop[n_beats] = s;
		s_eop[n_beats] = e;
		s_empty[n_beats] = 3'($random(seed));
		s_data[n_beats] = d;
		s_we[n_beats] = 1'b0;
		s_ante[n_beats] = 0;
		s_first[n_beats] = 1'b0;
		s_last[n_beats] = 1'b0;
		n_beats++;
	endtask

	// beats 0 to 4 with the iq flag set and pc id zero
	task automatic add_header(input logic [15:0] etype, input logic [7:0] stype, input logic more);
		add_beat(1'b1, 1'b1, 1'b0, rand_word());
		add_beat(1'b1, 1'b0, 1'b0, rand_word());
		add_beat(1'b1, 1'b0, 1'b0, eth_word(rand_word(), etype, 1'b1, 16'h0000));
		add_beat(1'b1, 1'b0, 1'b0, rand_word());
		add_beat(1'b1, 1'b0, 1'b0,
			sec_word(rand_word(), hdr_frame, hdr_slot, hdr_symbol, more, stype));
	endtask

	// index beat then one block with an idle cycle before data beat gap_at
	task automatic add_block(input logic [7:0] idx, input logic last_blk, input int gap_at,
		input logic routed);
		add_beat(1'b1, 1'b0, 1'b0, index_word(rand_word(), idx));
		for (int i = 0; i < BLK_LEN; i++)
		begin
			if (i == gap_at)
				add_beat(1'b0, 1'b0, 1'b0, rand_word());
			add_beat(1'b1, 1'b0, last_blk && (i == BLK_LEN - 1), rand_word());
			s_we[n_beats-1] = routed;
			s_ante[n_beats-1] = ante_of(idx);
			s_first[n_beats-1] = (i == 0);
			s_last[n_beats-1] = (i == BLK_LEN - 1);
		end
	endtask

	task automatic play();
		for (int i = 0; i < TAIL_LEN; i++)
			add_beat(1'b0, 1'b0, 1'b0, 64'h0);
		for (int j = 0; j < n_beats; j++)
		begin
			@(posedge clk_in);
			st_valid <= s_valid[j];
			st_sop <= s_sop[j];
			st_eop <= s_eop[j];
			st_empty <= s_empty[j];
			st_data <= s_data[j];
			@(negedge clk_in);
			c_restart[j] = arm_restart;
			c_arm[j] = {arm_valid, arm_sop, arm_eop, arm_empty};
			c_arm_data[j] = arm_data;
			c_valid[j] = ante_valid;
			c_sop[j] = ante_sop;
			c_eop[j] = ante_eop;
			c_data[j] = ante_data;
			c_frame[j] = ante_frame;
			c_slot[j] = ante_slot;
			c_symbol[j] = ante_symbol;
		end
	endtask

	task automatic check_arm_copy();
		for (int j = 1; j < n_beats; j++)
		begin
			if (c_arm[j] !== {s_valid[j-1], s_sop[j-1], s_eop[j-1], s_empty[j-1]})
				mismatch("arm flags", j, {s_valid[j-1], s_sop[j-1], s_eop[j-1], s_empty[j-1]},
					c_arm[j]);
			if (c_arm_data[j] !== s_data[j-1])
				mismatch("arm_data", j, s_data[j-1], c_arm_data[j]);
		end
	endtask

	// high from beat rise up to but not including beat fall
	task automatic check_restart(input int rise, input int fall);
		logic exp;
		for (int j = 1; j < n_beats; j++)
		begin
			exp = (j >= rise) && (j < fall);
			if (c_restart[j] !== exp)
				mismatch("arm_restart", j, exp, c_restart[j]);
		end
	endtask

	task automatic check_antenna();
		logic [ANTE_N-1:0] exp_vld;
		int a;
		for (int j = 1; j < n_beats; j++)
		begin
			a = s_ante[j-1];
			exp_vld = s_we[j-1] ? ante_mask(a) : '0;
			if (c_valid[j] !== exp_vld)
				mismatch("ante_valid", j, exp_vld, c_valid[j]);
			if (c_sop[j] !== (exp_vld & {ANTE_N{s_first[j-1]}}))
				mismatch("ante_sop", j, exp_vld & {ANTE_N{s_first[j-1]}}, c_sop[j]);
			if (c_eop[j] !== (exp_vld & {ANTE_N{s_last[j-1]}}))
				mismatch("ante_eop", j, exp_vld & {ANTE_N{s_last[j-1]}}, c_eop[j]);
			if (s_we[j-1])
			begin
				if (c_data[j][a] !== s_data[j-1])
					mismatch("ante_data", j, s_data[j-1], c_data[j][a]);
				if ({c_frame[j][a], c_slot[j][a], c_symbol[j][a]} !==
					{hdr_frame, hdr_slot, hdr_symbol})
					mismatch("frame/slot/symbol", j, {hdr_frame, hdr_slot, hdr_symbol},
						{c_frame[j][a], c_slot[j][a], c_symbol[j][a]});
			end
		end
	endtask

	task automatic test_reset();
		start_test("reset");
		repeat (10) @(posedge clk_in);
		@(negedge clk_in);
		if (st_ready !== 1'b0)
			mismatch("st_ready in reset", 0, 0, st_ready);
		if ({arm_restart, arm_valid, arm_sop, arm_eop, arm_empty} !== 7'b0)
			mismatch("arm flags in reset", 0, 0,
				{arm_restart, arm_valid, arm_sop, arm_eop, arm_empty});
		if (arm_data !== 64'h0)
			mismatch("arm_data in reset", 0, 0, arm_data);
		if ({ante_valid, ante_sop, ante_eop} !== '0)
			mismatch("ante flags in reset", 0, 0, {ante_valid, ante_sop, ante_eop});
		@(posedge clk_in);
		rst_n <= 1'b1;
		@(negedge clk_in);
		if (st_ready !== 1'b1)
			mismatch("st_ready after reset", 0, 1, st_ready);
		end_test();
	endtask

	task automatic test_arm_copy();
		start_test("arm_copy");
		add_header(16'h0800, 8'h00, 1'b0);
		for (int i = 0; i < 8; i++)
			add_beat((i == 7) || (($random(seed) & 3) != 0), 1'b0, i == 7, rand_word());
		play();
		check_arm_copy();
		check_restart(0, 0);
		end_test();
	endtask

	task automatic test_restart();
		int sop_b;
		start_test("restart");
		add_header(16'hAEFE, 8'h00, 1'b0);
		add_block(8'h00, 1'b1, -1, 1'b1);
		sop_b = n_beats;
		add_header(16'h0800, 8'h00, 1'b0);
		add_beat(1'b1, 1'b0, 1'b1, rand_word());
		play();
		// ethertype sits at beat 2 of the first frame
		check_restart(2 + 3, sop_b + 2);
		check_antenna();
		end_test();
	endtask

	task automatic test_single_block();
		start_test("single_block");
		add_header(16'hAEFE, 8'h00, 1'b0);
		add_block(8'h03, 1'b1, -1, 1'b1);
		play();
		check_antenna();
		end_test();
	endtask

	task automatic test_repeat_blocks();
		start_test("repeat_blocks");
		add_header(16'hAEFE, 8'h00, 1'b1);
		add_block(8'h01, 1'b0, -1, 1'b1);
		add_beat(1'b1, 1'b0, 1'b0, repeat_word(rand_word(), 1'b0));
		// 0x0e lands on antenna 6
		add_block(8'h0E, 1'b1, -1, 1'b1);
		play();
		check_antenna();
		end_test();
	endtask

	task automatic test_reject();
		start_test("reject");
		add_header(16'h88F7, 8'h00, 1'b0);
		add_block(8'h02, 1'b1, -1, 1'b0);
		add_header(16'hAEFE, 8'h01, 1'b0);
		add_block(8'h02, 1'b1, -1, 1'b0);
		play();
		check_antenna();
		end_test();
	endtask

	task automatic test_idle_gap();
		start_test("idle_gap");
		add_header(16'hAEFE, 8'h00, 1'b0);
		add_block(8'h05, 1'b1, 4, 1'b1);
		play();
		check_antenna();
		end_test();
	endtask

	initial
	begin
		seed = 32'h2c2d;
		rst_n = 1'b0;
		st_data = '0;
		st_valid = 1'b0;
		st_sop = 1'b0;
		st_eop = 1'b0;
		st_empty = '0;
		st_error = 1'b0;
		test_reset();
		test_arm_copy();
		test_restart();
		test_single_block();
		test_repeat_blocks();
		test_reject();
		test_idle_gap();
		$display("tests run %0d, errors %0d", test_cnt, err_cnt);
		if (err_cnt == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- flist.f
+incdir+include
rtl/dl_pkg.sv
rtl/arm_bypass.sv
rtl/iq_section_parser.sv
rtl/ante_fanout.sv
rtl/dl_distribt.sv
dv/dl_distribt_tb.sv
